// File: core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

  ////////////////////////////////////////
  // next-pc sources and exception targets
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_ERET      = 3'd4
  } pc_sel_e;

  typedef enum logic [1:0] {
    EXC_ILLINSN = 2'd0,
    EXC_ECALL   = 2'd1,
    EXC_LSUERR  = 2'd2,
    EXC_IRQ     = 2'd3
  } exc_sel_e;

  // low byte of each vector, placed under boot_addr[31:8]
  localparam logic [7:0] EXC_OFF_RST     = 8'h80;
  localparam logic [7:0] EXC_OFF_ILLINSN = 8'h84;
  localparam logic [7:0] EXC_OFF_ECALL   = 8'h88;
  localparam logic [7:0] EXC_OFF_LSUERR  = 8'h8C;

  ////////////////////////////////////////
  // structs crossing module boundaries
  ////////////////////////////////////////

  // control from the later pipeline stages
  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_sel;
    exc_sel_e    exc_sel;
    logic [4:0]  irq_vec;
    logic [31:0] jump_target_id;
    logic [31:0] branch_target_ex;
    logic [31:0] epc;
  } pc_ctrl_t;

  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } imem_rsp_t;

  // contents of the IF/ID register
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        is_compressed;
    logic        illegal_c;
  } if_id_t;

  // one fetched word and its word address
  typedef struct packed {
    logic [31:0] data;
    logic [31:0] addr;
  } fetch_word_t;

endpackage

`default_nettype wire

// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // major opcodes of the expanded forms
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // 32-bit funct fields
  localparam logic [2:0] FUNCT3_LW   = 3'b010;
  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_JALR = 3'b000;
  localparam logic [6:0] FUNCT7_ADD  = 7'b0000000;

  ////////////////////////////////////////
  // rvc quadrants and funct3 codes
  ////////////////////////////////////////

  localparam logic [1:0] RVC_Q0 = 2'b00;
  localparam logic [1:0] RVC_Q1 = 2'b01;
  localparam logic [1:0] RVC_Q2 = 2'b10;

  localparam logic [2:0] CF3_LW     = 3'b010;
  localparam logic [2:0] CF3_ADDI   = 3'b000;
  localparam logic [2:0] CF3_LI     = 3'b010;
  localparam logic [2:0] CF3_MV_ADD = 3'b100;

  // 3-bit compressed registers map onto x8..x15
  localparam logic [4:0] REG_X0      = 5'd0;
  localparam logic [4:0] REG_X8_BASE = 5'd8;

endpackage

`default_nettype wire

// File: fetch_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_fifo (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        flush_i,
  input  wire logic                        push_i,
  input  wire core_ctrl_pkg::fetch_word_t  push_word_i,
  input  wire logic                        pop_i,
  output core_ctrl_pkg::fetch_word_t       head_o,
  output logic                             head_valid_o,
  output core_ctrl_pkg::fetch_word_t       second_o,
  output logic                             second_valid_o,
  output logic [1:0]                       count_o
);

  // entry 0 is always the head, entry 1 the word behind it
  core_ctrl_pkg::fetch_word_t entry_q [2];
  logic [1:0]                 cnt_q;
  logic                       wr_idx;

  // slot the pushed word lands in, after any pop has shifted
  assign wr_idx = pop_i ? (cnt_q == 2'd2) : (cnt_q != 2'd0);

  always_ff @(posedge clk) begin
    if (pop_i) begin
      entry_q[0] <= entry_q[1];
    end
    if (push_i) begin
      entry_q[wr_idx] <= push_word_i;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= 2'd0;
    end else if (flush_i) begin
      // a flush drops everything, the same-cycle push included
      cnt_q <= 2'd0;
    end else begin
      cnt_q <= cnt_q + {1'b0, push_i} - {1'b0, pop_i};
    end
  end

  // both entries visible for unaligned joins
  assign head_o         = entry_q[0];
  assign second_o       = entry_q[1];
  assign head_valid_o   = (cnt_q != 2'd0);
  assign second_valid_o = (cnt_q == 2'd2);
  assign count_o        = cnt_q;

endmodule

`default_nettype wire

// File: prefetch_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module prefetch_buffer (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       fetch_en_i,
  input  wire logic                       branch_i,
  input  wire logic [31:0]                branch_addr_i,
  input  wire logic                       pop_i,
  output core_ctrl_pkg::fetch_word_t      word_o,
  output logic                            valid_o,
  output core_ctrl_pkg::fetch_word_t      next_word_o,
  output logic                            next_valid_o,
  output core_ctrl_pkg::imem_req_t        imem_req_o,
  input  wire core_ctrl_pkg::imem_rsp_t   imem_rsp_i,
  output logic                            busy_o
);

  logic [1:0]  fifo_cnt, fifo_cnt_n;
  logic [1:0]  out_cnt_q, out_cnt_n;
  logic [1:0]  discard_q, discard_n;
  logic        req_q, req_stale_q;
  logic [31:0] req_addr_q, fetch_addr_q, resp_addr_q, base_addr;
  logic        accepted, hold, drop, push, room, issue;
  core_ctrl_pkg::fetch_word_t push_word;

  ////////////////////////////////////////
  // request side
  ////////////////////////////////////////

  assign accepted = req_q & imem_rsp_i.gnt;
  // ungranted request, address must stay put
  assign hold     = req_q & ~imem_rsp_i.gnt;

  // stale responses die on a branch or while discards remain
  assign drop = imem_rsp_i.rvalid & (branch_i | (discard_q != 2'd0));
  assign push = imem_rsp_i.rvalid & ~drop;

  assign out_cnt_n  = out_cnt_q + {1'b0, accepted} - {1'b0, imem_rsp_i.rvalid};
  assign fifo_cnt_n = branch_i ? 2'd0 : fifo_cnt + {1'b0, push} - {1'b0, pop_i};

  // fifo words plus requests in flight never pass two
  assign room  = ({1'b0, fifo_cnt_n} + {1'b0, out_cnt_n}) < 3'd2;
  assign issue = ~hold & fetch_en_i & room;

  assign base_addr = branch_i ? branch_addr_i : fetch_addr_q;

  always_comb begin
    if (branch_i) begin
      // everything still in flight belongs to the old path
      discard_n = out_cnt_n;
    end else begin
      discard_n = discard_q - {1'b0, drop} + {1'b0, accepted & req_stale_q};
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      req_q       <= 1'b0;
      req_stale_q <= 1'b0;
      out_cnt_q   <= 2'd0;
      discard_q   <= 2'd0;
    end else begin
      out_cnt_q <= out_cnt_n;
      discard_q <= discard_n;
      if (hold) begin
        // held request now points at the old path
        if (branch_i) begin
          req_stale_q <= 1'b1;
        end
      end else begin
        req_q       <= issue;
        req_stale_q <= 1'b0;
      end
    end
  end

  // address registers
  always_ff @(posedge clk) begin
    if (!hold) begin
      req_addr_q <= base_addr;
    end
    if (branch_i || issue) begin
      fetch_addr_q <= issue ? base_addr + 32'd4 : base_addr;
    end
    // address of the next response kept
    if (branch_i) begin
      resp_addr_q <= branch_addr_i;
    end else if (push) begin
      resp_addr_q <= resp_addr_q + 32'd4;
    end
  end

  assign imem_req_o.req  = req_q;
  assign imem_req_o.addr = req_addr_q;

  assign push_word.data = imem_rsp_i.rdata;
  assign push_word.addr = resp_addr_q;

  fetch_fifo u_fetch_fifo (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (branch_i),
    .push_i         (push),
    .push_word_i    (push_word),
    .pop_i          (pop_i),
    .head_o         (word_o),
    .head_valid_o   (valid_o),
    .second_o       (next_word_o),
    .second_valid_o (next_valid_o),
    .count_o        (fifo_cnt)
  );

  assign busy_o = req_q | (out_cnt_q != 2'd0);

endmodule

`default_nettype wire

// File: compressed_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module compressed_decoder (
  input  wire logic [31:0] instr_i,
  output logic [31:0]      instr_o,
  output logic             is_compressed_o,
  output logic             illegal_o
);

  logic [2:0]  cf3;
  logic [4:0]  rd, rs2, rd_p, rs1_p;
  logic [11:0] imm_ci, uimm_lw;

  // instruction fields of the 16-bit forms
  assign cf3   = instr_i[15:13];
  assign rd    = instr_i[11:7];
  assign rs2   = instr_i[6:2];
  assign rd_p  = rv_isa_pkg::REG_X8_BASE | {2'b00, instr_i[4:2]};
  assign rs1_p = rv_isa_pkg::REG_X8_BASE | {2'b00, instr_i[9:7]};

  // sign-extended 6-bit immediate of c.addi and c.li
  assign imm_ci  = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};
  // word-scaled offset of c.lw
  assign uimm_lw = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00};

  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    // unknown encodings go through untouched, flagged
    instr_o   = instr_i;
    illegal_o = is_compressed_o;

    case (instr_i[1:0])
      rv_isa_pkg::RVC_Q0: begin
        // c.lw
        if (cf3 == rv_isa_pkg::CF3_LW) begin
          instr_o   = {uimm_lw, rs1_p, rv_isa_pkg::FUNCT3_LW, rd_p, rv_isa_pkg::OPC_LOAD};
          illegal_o = 1'b0;
        end
      end

      rv_isa_pkg::RVC_Q1: begin
        if (cf3 == rv_isa_pkg::CF3_ADDI) begin
          // c.addi, rd = rd + imm
          instr_o   = {imm_ci, rd, rv_isa_pkg::FUNCT3_ADD, rd, rv_isa_pkg::OPC_OP_IMM};
          illegal_o = 1'b0;
        end else if (cf3 == rv_isa_pkg::CF3_LI) begin
          // c.li, rd = x0 + imm
          instr_o   = {imm_ci, rv_isa_pkg::REG_X0, rv_isa_pkg::FUNCT3_ADD, rd,
                       rv_isa_pkg::OPC_OP_IMM};
          illegal_o = 1'b0;
        end
      end

      rv_isa_pkg::RVC_Q2: begin
        if (cf3 == rv_isa_pkg::CF3_MV_ADD) begin
          if (rs2 != rv_isa_pkg::REG_X0) begin
            // bit 12 picks c.add over c.mv
            instr_o   = {rv_isa_pkg::FUNCT7_ADD, rs2,
                         instr_i[12] ? rd : rv_isa_pkg::REG_X0,
                         rv_isa_pkg::FUNCT3_ADD, rd, rv_isa_pkg::OPC_OP};
            illegal_o = 1'b0;
          end else if (!instr_i[12] && rd != rv_isa_pkg::REG_X0) begin
            // c.jr, jalr x0, 0(rs1)
            instr_o   = {12'b0, rd, rv_isa_pkg::FUNCT3_JALR, rv_isa_pkg::REG_X0,
                         rv_isa_pkg::OPC_JALR};
            illegal_o = 1'b0;
          end
        end
      end

      default: begin
        // full 32-bit word, nothing to expand
        instr_o = instr_i;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: if_stage.sv
`timescale 1ns/1ns
`default_nettype none

module if_stage (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic [31:0]               boot_addr_i,
  input  wire logic                      fetch_en_i,
  input  wire core_ctrl_pkg::pc_ctrl_t   pc_ctrl_i,
  output core_ctrl_pkg::imem_req_t       imem_req_o,
  input  wire core_ctrl_pkg::imem_rsp_t  imem_rsp_i,
  input  wire logic                      halt_i,
  input  wire logic                      id_ready_i,
  input  wire logic                      clear_id_execute_i,
  output logic                           if_valid_o,
  output logic                           if_ready_o,
  output core_ctrl_pkg::if_id_t          if_id_o,
  output logic                           id_execute_o,
  output logic                           branch_done_o,
  output logic                           if_busy_o
);

  typedef enum logic [1:0] {IDLE, WAIT_ALIGNED, WAIT_UNALIGNED} offset_state_e;

  offset_state_e              state_q, state_n;
  core_ctrl_pkg::fetch_word_t head_word, next_word;
  logic                       head_valid, next_valid, fetch_pop;
  logic                       branch_req, branch_pend_q, pc_set_ok;
  logic                       valid, unaligned;
  logic [1:0]                 is_compressed;
  logic [31:0]                boot_pc, exc_pc, pc_target, branch_target;
  logic [31:0]                instr_raw, instr_exp, pc_if;
  logic                       instr_c, instr_ill;

  ////////////////////////////////////////
  // next-pc selection
  ////////////////////////////////////////

  assign boot_pc = {boot_addr_i[31:8], core_ctrl_pkg::EXC_OFF_RST};

  always_comb begin
    unique case (pc_ctrl_i.exc_sel)
      core_ctrl_pkg::EXC_ILLINSN: exc_pc = {boot_addr_i[31:8], core_ctrl_pkg::EXC_OFF_ILLINSN};
      core_ctrl_pkg::EXC_ECALL:   exc_pc = {boot_addr_i[31:8], core_ctrl_pkg::EXC_OFF_ECALL};
      core_ctrl_pkg::EXC_LSUERR:  exc_pc = {boot_addr_i[31:8], core_ctrl_pkg::EXC_OFF_LSUERR};
      // vectored interrupt, one word per line
      default: exc_pc = {boot_addr_i[31:8], 1'b0, pc_ctrl_i.irq_vec, 2'b00};
    endcase
  end

  always_comb begin
    case (pc_ctrl_i.pc_sel)
      core_ctrl_pkg::PC_JUMP:      pc_target = {pc_ctrl_i.jump_target_id[31:1], 1'b0};
      core_ctrl_pkg::PC_BRANCH:    pc_target = {pc_ctrl_i.branch_target_ex[31:1], 1'b0};
      core_ctrl_pkg::PC_EXCEPTION: pc_target = exc_pc;
      core_ctrl_pkg::PC_ERET:      pc_target = pc_ctrl_i.epc;
      default:                     pc_target = boot_pc;
    endcase
  end

  // one branch request per pc_set until an instruction issues
  assign pc_set_ok     = pc_ctrl_i.pc_set & ~branch_pend_q;
  assign branch_target = pc_set_ok ? pc_target : boot_pc;

  prefetch_buffer u_prefetch_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_en_i    (fetch_en_i),
    .branch_i      (branch_req),
    .branch_addr_i ({branch_target[31:2], 2'b00}),
    .pop_i         (fetch_pop),
    .word_o        (head_word),
    .valid_o       (head_valid),
    .next_word_o   (next_word),
    .next_valid_o  (next_valid),
    .imem_req_o    (imem_req_o),
    .imem_rsp_i    (imem_rsp_i),
    .busy_o        (if_busy_o)
  );

  ////////////////////////////////////////
  // offset FSM
  ////////////////////////////////////////

  // compressed check on lower and upper half
  assign is_compressed[0] = (head_word.data[1:0] != 2'b11);
  assign is_compressed[1] = (head_word.data[17:16] != 2'b11);

  assign unaligned = (state_q == WAIT_UNALIGNED);

  always_comb begin
    case (state_q)
      WAIT_ALIGNED:   valid = head_valid;
      // upper 32-bit instruction also needs the next word
      WAIT_UNALIGNED: valid = head_valid & (is_compressed[1] | next_valid);
      default:        valid = 1'b0;
    endcase
    // redirect kills whatever sits here now
    if (pc_set_ok) begin
      valid = 1'b0;
    end
  end

  assign if_ready_o = valid & id_ready_i;
  assign if_valid_o = if_ready_o & ~halt_i;

  always_comb begin
    state_n    = state_q;
    fetch_pop  = 1'b0;
    branch_req = 1'b0;
    case (state_q)
      IDLE: begin
        // first fetch goes to the reset vector
        if (fetch_en_i) begin
          branch_req = 1'b1;
          state_n    = WAIT_ALIGNED;
        end
      end
      WAIT_ALIGNED: begin
        if (if_valid_o) begin
          if (is_compressed[0]) begin
            state_n = WAIT_UNALIGNED;
          end else begin
            fetch_pop = 1'b1;
          end
        end
      end
      WAIT_UNALIGNED: begin
        // either way the head word is used up
        if (if_valid_o) begin
          fetch_pop = 1'b1;
          if (is_compressed[1]) begin
            state_n = WAIT_ALIGNED;
          end
        end
      end
      default: state_n = IDLE;
    endcase
    if (pc_set_ok) begin
      branch_req = 1'b1;
      state_n    = pc_target[1] ? WAIT_UNALIGNED : WAIT_ALIGNED;
    end
  end

  ////////////////////////////////////////
  // expansion and IF/ID register
  ////////////////////////////////////////

  // upper half joined with the next word's lower half
  assign instr_raw = unaligned ? {next_word.data[15:0], head_word.data[31:16]}
                               : head_word.data;
  assign pc_if     = {head_word.addr[31:2], unaligned, 1'b0};

  compressed_decoder u_compressed_decoder (
    .instr_i         (instr_raw),
    .instr_o         (instr_exp),
    .is_compressed_o (instr_c),
    .illegal_o       (instr_ill)
  );

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= IDLE;
      branch_pend_q <= 1'b0;
      id_execute_o  <= 1'b0;
    end else begin
      state_q <= state_n;
      // pending until the new path issues
      if (if_valid_o) begin
        branch_pend_q <= 1'b0;
      end else if (branch_req) begin
        branch_pend_q <= 1'b1;
      end
      if (if_valid_o) begin
        id_execute_o <= 1'b1;
      end else if (clear_id_execute_i) begin
        id_execute_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid_o) begin
      if_id_o <= '{instr: instr_exp, pc: pc_if, is_compressed: instr_c, illegal_c: instr_ill};
    end
  end

  assign branch_done_o = branch_pend_q;

endmodule

`default_nettype wire

// File: fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic [31:0]               boot_addr_i,
  input  wire logic                      fetch_en_i,
  input  wire core_ctrl_pkg::pc_ctrl_t   pc_ctrl_i,
  output core_ctrl_pkg::imem_req_t       imem_req_o,
  input  wire core_ctrl_pkg::imem_rsp_t  imem_rsp_i,
  input  wire logic                      halt_i,
  input  wire logic                      id_ready_i,
  input  wire logic                      clear_id_execute_i,
  output logic                           if_valid_o,
  output logic                           if_ready_o,
  output core_ctrl_pkg::if_id_t          if_id_o,
  output logic                           id_execute_o,
  output logic                           branch_done_o,
  output logic                           if_busy_o
);

  // boundary seen by the testbench, all logic lives in the stage
  if_stage u_if_stage (
    .clk                (clk),
    .rst_n              (rst_n),
    .boot_addr_i        (boot_addr_i),
    .fetch_en_i         (fetch_en_i),
    .pc_ctrl_i          (pc_ctrl_i),
    .imem_req_o         (imem_req_o),
    .imem_rsp_i         (imem_rsp_i),
    .halt_i             (halt_i),
    .id_ready_i         (id_ready_i),
    .clear_id_execute_i (clear_id_execute_i),
    .if_valid_o         (if_valid_o),
    .if_ready_o         (if_ready_o),
    .if_id_o            (if_id_o),
    .id_execute_o       (id_execute_o),
    .branch_done_o      (branch_done_o),
    .if_busy_o          (if_busy_o)
  );

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

  // reset released just after an edge, like the other inputs
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_top;

  localparam int NUM_ROWS   = 20;
  localparam int RST_CYCLES = 8;
  localparam int TIMEOUT    = NUM_ROWS * 20 + RST_CYCLES;

  localparam logic [1:0] NONE = 2'd0;
  localparam logic [1:0] HALT = 2'd1;
  localparam logic [1:0] NRDY = 2'd2;

  // one issued instruction per row with the redirect and stall before it
  typedef struct packed {
    core_ctrl_pkg::pc_sel_e  sel;
    core_ctrl_pkg::exc_sel_e exc;
    logic [4:0]              vec;
    logic [31:0]             tgt;
    logic [1:0]              stall;
    logic [3:0]              stall_len;
    core_ctrl_pkg::if_id_t   exp;
  } row_t;

  logic                      clk, rst_n;
  logic [31:0]               boot_addr;
  logic                      fetch_en, halt, id_ready, clear_exec;
  core_ctrl_pkg::pc_ctrl_t   pc_ctrl;
  core_ctrl_pkg::imem_req_t  imem_req;
  core_ctrl_pkg::imem_rsp_t  imem_rsp = '0;
  logic                      if_valid, if_ready, id_execute, branch_done, if_busy;
  core_ctrl_pkg::if_id_t     if_id;

  row_t        rows [NUM_ROWS];
  int          n_rows = 0;
  int          err_cnt = 0;
  int          cycle_cnt = 0;
  logic [31:0] lfsr_q = 32'h7db9bc04;

  tb_clkgen #(.PERIOD(8), .RST_CYCLES(RST_CYCLES)) u_clkgen (.clk(clk), .rst_n(rst_n));

  fetch_top u_fetch_top (
    .clk                (clk),
    .rst_n              (rst_n),
    .boot_addr_i        (boot_addr),
    .fetch_en_i         (fetch_en),
    .pc_ctrl_i          (pc_ctrl),
    .imem_req_o         (imem_req),
    .imem_rsp_i         (imem_rsp),
    .halt_i             (halt),
    .id_ready_i         (id_ready),
    .clear_id_execute_i (clear_exec),
    .if_valid_o         (if_valid),
    .if_ready_o         (if_ready),
    .if_id_o            (if_id),
    .id_execute_o       (id_execute),
    .branch_done_o      (branch_done),
    .if_busy_o          (if_busy)
  );

  ////////////////////////////////////////
  // random delays and program image
  ////////////////////////////////////////

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic int draw_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_q[0]);
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
    end
    return v;
  endfunction

  // hand-placed rvc code among 32-bit words made from their address
  function automatic logic [31:0] program_word(input logic [31:0] a);
    case (a)
      32'h1100: program_word = 32'h8593_4515;
      32'h1104: program_word = 32'h85B2_00A5;
      32'h1108: program_word = 32'h147D_4144;
      32'h110C: program_word = 32'h8082_952E;
      32'h1110: program_word = 32'h6285_0000;
      32'h1200: program_word = 32'h57F5_0013;
      default:  program_word = {a[31:2], 2'b11};
    endcase
  endfunction

  // memory model gives gnt after 0..2 cycles and rvalid 1..3 cycles after grant
  int          gnt_wait = -1;
  int          rsp_delay [$];
  logic [31:0] rsp_addr [$];

  always @(posedge clk) begin
    #1;
    if (!rst_n) begin
      imem_rsp = '0;
      gnt_wait = -1;
      rsp_delay.delete();
      rsp_addr.delete();
    end else begin
      imem_rsp.rvalid = 1'b0;
      if (rsp_addr.size() > 0 && rsp_delay[0] == 0) begin
        imem_rsp.rvalid = 1'b1;
        imem_rsp.rdata  = program_word(rsp_addr[0]);
        void'(rsp_addr.pop_front());
        void'(rsp_delay.pop_front());
      end
      foreach (rsp_delay[i]) begin
        if (rsp_delay[i] > 0) begin
          rsp_delay[i] = rsp_delay[i] - 1;
        end
      end
      imem_rsp.gnt = 1'b0;
      if (imem_req.req) begin
        if (gnt_wait < 0) begin
          gnt_wait = draw_bits(2) % 3;
        end
        if (gnt_wait == 0) begin
          // accepted on the coming edge
          imem_rsp.gnt = 1'b1;
          rsp_addr.push_back(imem_req.addr);
          rsp_delay.push_back(draw_bits(2) % 3);
          gnt_wait = -1;
        end else begin
          gnt_wait = gnt_wait - 1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // checks and table
  ////////////////////////////////////////

  task automatic check_if_id(input string name, input core_ctrl_pkg::if_id_t got,
                             input core_ctrl_pkg::if_id_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h exp %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h exp %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic add_row(input logic [2:0] sel, input logic [1:0] exc, input logic [4:0] vec,
                         input logic [31:0] tgt, input logic [1:0] stall,
                         input logic [3:0] stall_len, input logic [31:0] instr,
                         input logic [31:0] pc, input logic c, input logic ill);
    rows[n_rows] = '{sel: core_ctrl_pkg::pc_sel_e'(sel), exc: core_ctrl_pkg::exc_sel_e'(exc),
                     vec: vec, tgt: tgt, stall: stall, stall_len: stall_len,
                     exp: '{instr: instr, pc: pc, is_compressed: c, illegal_c: ill}};
    n_rows++;
  endtask

  // PC_BOOT in a row means no redirect
  // expansions worked out by hand
  task automatic fill_table();
    add_row(core_ctrl_pkg::PC_BOOT, 2'd0, 5'd0, 32'h0, NONE, 4'd0,
            32'h0000_1083, 32'h1080, 1'b0, 1'b0);
    add_row(core_ctrl_pkg::PC_BOOT, 2'd0, 5'd0, 32'h0, HALT, 4'd5,
            32'h0000_1087, 32'h1084, 1'b0, 1'b0);
    add_row(core_ctrl_pkg::PC_BOOT, 2'd0, 5'd0, 32'h0, NRDY, 4'd4,
            32'h0000_108B, 32'h1088, 1'b0, 1'b0);
    // c.li a0,5 then addi a1,a1,10 across the word boundary
    add_row(core_ctrl_pkg::PC_JUMP, 2'd0, 5'd0, 32'h1100, NONE, 4'd0,
            32'h0050_0513, 32'h1100, 1'b1, 1'b0);
    add_row(core_ctrl_pkg::PC_BOOT, 2'd0, 5'd0, 32'h0, NONE, 4'd0,
            32'h00A5_8593, 32'h1102, 1'b0, 1'b0);
    add_row(core_ctrl_pkg::PC_BOOT, 2'd0, 5'd0, 32'h0, HALT, 4'd3,
            32'h00C0_05B3, 32'h1106, 1'b1, 1'b0);
    add_row(core_ctrl_pkg::PC_BOOT, 2'd0, 5'd0, 32'h0, NONE, 4'd0,
            32'h0045_2483, 32'h1108, 1'b1, 1'b0);
    add_row(core_ctrl_pkg::PC_BOOT, 2'd0, 5'd0, 32'h0, NONE, 4'd0,
            32'hFFF4_0413, 32'h110A, 1'b1, 1'b0);
    add_row(core_ctrl_pkg::PC_BOOT, 2'd0, 5'd0, 32'h0, NONE, 4'd0,
            32'h00B5_0533, 32'h110C, 1'b1, 1'b0);
    add_row(core_ctrl_pkg::PC_BOOT, 2'd0, 5'd0, 32'h0, NONE, 4'd0,
            32'h0000_8067, 32'h110E, 1'b1, 1'b0);
    // all-zero half word passes through flagged with the raw word
    add_row(core_ctrl_pkg::PC_BOOT, 2'd0, 5'd0, 32'h0, NONE, 4'd0,
            32'h6285_0000, 32'h1110, 1'b1, 1'b1);
    add_row(core_ctrl_pkg::PC_JUMP, 2'd0, 5'd0, 32'h1202, NONE, 4'd0,
            32'hFFD0_0793, 32'h1202, 1'b1, 1'b0);
    add_row(core_ctrl_pkg::PC_BOOT, 2'd0, 5'd0, 32'h0, NONE, 4'd0,
            32'h0000_1207, 32'h1204, 1'b0, 1'b0);
    add_row(core_ctrl_pkg::PC_BRANCH, 2'd0, 5'd0, 32'h1300, NONE, 4'd0,
            32'h0000_1303, 32'h1300, 1'b0, 1'b0);
    add_row(core_ctrl_pkg::PC_EXCEPTION, core_ctrl_pkg::EXC_ILLINSN, 5'd0, 32'h0, NONE, 4'd0,
            32'h0000_1087, 32'h1084, 1'b0, 1'b0);
    add_row(core_ctrl_pkg::PC_EXCEPTION, core_ctrl_pkg::EXC_ECALL, 5'd0, 32'h0, NONE, 4'd0,
            32'h0000_108B, 32'h1088, 1'b0, 1'b0);
    add_row(core_ctrl_pkg::PC_EXCEPTION, core_ctrl_pkg::EXC_LSUERR, 5'd0, 32'h0, NONE, 4'd0,
            32'h0000_108F, 32'h108C, 1'b0, 1'b0);
    // irq vector 5 lands at offset 5*4
    add_row(core_ctrl_pkg::PC_EXCEPTION, core_ctrl_pkg::EXC_IRQ, 5'd5, 32'h0, NONE, 4'd0,
            32'h0000_1017, 32'h1014, 1'b0, 1'b0);
    add_row(core_ctrl_pkg::PC_ERET, 2'd0, 5'd0, 32'h1100, NONE, 4'd0,
            32'h0050_0513, 32'h1100, 1'b1, 1'b0);
    add_row(core_ctrl_pkg::PC_BOOT, 2'd0, 5'd0, 32'h0, NRDY, 4'd2,
            32'h00A5_8593, 32'h1102, 1'b0, 1'b0);
  endtask

  ////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT);
      $display("errors: %0d mismatches, 1 timeout", err_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    row_t                  r;
    logic                  seen;
    core_ctrl_pkg::if_id_t last;

    boot_addr  = 32'h0000_1000;
    fetch_en   = 1'b0;
    pc_ctrl    = '0;
    halt       = 1'b0;
    id_ready   = 1'b0;
    clear_exec = 1'b0;
    last       = '0;
    fill_table();

    @(negedge clk);
    check_bit("imem_req_o.req", imem_req.req, 1'b0);
    check_bit("if_valid_o", if_valid, 1'b0);
    check_bit("if_ready_o", if_ready, 1'b0);
    check_bit("id_execute_o", id_execute, 1'b0);
    check_bit("branch_done_o", branch_done, 1'b0);
    check_bit("if_busy_o", if_busy, 1'b0);
    @(posedge rst_n);
    @(posedge clk);
    #1 fetch_en = 1'b1;

    for (int i = 0; i < n_rows; i++) begin
      r = rows[i];
      // redirect only once the previous path has issued
      if (r.sel != core_ctrl_pkg::PC_BOOT) begin
        check_bit("branch_done_o", branch_done, 1'b0);
        pc_ctrl = '{pc_set: 1'b1, pc_sel: r.sel, exc_sel: r.exc, irq_vec: r.vec,
                    jump_target_id: r.tgt, branch_target_ex: r.tgt, epc: r.tgt};
        @(posedge clk);
        #1 pc_ctrl = '0;
        check_bit("branch_done_o", branch_done, 1'b1);
      end
      for (int s = 0; s < int'(r.stall_len); s++) begin
        halt     = (r.stall == HALT);
        id_ready = (r.stall == HALT);
        @(negedge clk);
        check_bit("if_valid_o", if_valid, 1'b0);
        // decode not ready means fetch cannot be ready either
        if (r.stall == NRDY) begin
          check_bit("if_ready_o", if_ready, 1'b0);
        end
        check_if_id("if_id_o", if_id, last);
        @(posedge clk);
        #1;
      end
      halt     = 1'b0;
      id_ready = 1'b1;
      seen     = 1'b0;
      while (!seen) begin
        @(negedge clk);
        seen = if_valid;
        if (seen) begin
          check_bit("if_ready_o", if_ready, 1'b1);
        end
        // an open request keeps the fetch unit busy
        if (imem_req.req) begin
          check_bit("if_busy_o", if_busy, 1'b1);
        end
        @(posedge clk);
        #1;
      end
      id_ready = 1'b0;
      check_if_id("if_id_o", if_id, r.exp);
      check_bit("id_execute_o", id_execute, 1'b1);
      last       = r.exp;
      clear_exec = 1'b1;
      @(posedge clk);
      #1 clear_exec = 1'b0;
      check_bit("id_execute_o", id_execute, 1'b0);
    end

    // stop fetching and wait for the requests in flight to drain
    fetch_en = 1'b0;
    @(negedge clk);
    while (if_busy) begin
      @(negedge clk);
    end

    $display("errors: %0d mismatches, 0 timeouts", err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
core_ctrl_pkg.sv
rv_isa_pkg.sv
fetch_fifo.sv
prefetch_buffer.sv
compressed_decoder.sv
if_stage.sv
fetch_top.sv
tb_clkgen.sv
tb_fetch_top.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fetch_top -f all.f -Mdir obj_dir -o sim_fetch
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_fetch)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" <<< "$out"; then
  exit 0
fi
exit 1
